//--- rtl/fifo_settings.svh
`ifndef FIFO_SETTINGS_SVH
`define FIFO_SETTINGS_SVH

// codeword layout
`define DATA_WIDTH    39
`define PARITY_WIDTH  7

// buffer and status sizing
`define FIFO_DEPTH    8
`define ERR_CNT_WIDTH 16

`endif

//--- rtl/ecc_pkg.sv
`include "fifo_settings.svh"

package ecc_pkg;

    localparam int CW_WIDTH = `DATA_WIDTH + `PARITY_WIDTH;

    typedef logic [`PARITY_WIDTH-1:0] syndrome_t;

    typedef enum logic [1:0] {
        ERR_NONE      = 2'b00,
        ERR_CORRECTED = 2'b01,
        ERR_UNCORR    = 2'b10,
        ERR_PARITY    = 2'b11
    } err_kind_e;

    // check bits sit above the data
    typedef struct packed {
        logic [`PARITY_WIDTH-1:0] parity;
        logic [`DATA_WIDTH-1:0]   data;
    } cw_fields_s;

    typedef union packed {
        logic [CW_WIDTH-1:0] raw;
        cw_fields_s          fields;
    } codeword_u;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // SEC-DED check bit equations
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [`PARITY_WIDTH-1:0] ecc_encode(input logic [`DATA_WIDTH-1:0] d);
        logic [`PARITY_WIDTH-1:0] p;
        p[0] = d[0] ^ d[1] ^ d[3] ^ d[4] ^ d[6] ^ d[8] ^ d[10] ^ d[11] ^ d[13] ^ d[15]
             ^ d[17] ^ d[19] ^ d[21] ^ d[23] ^ d[25] ^ d[26] ^ d[28] ^ d[30] ^ d[32]
             ^ d[34] ^ d[36] ^ d[38];
        p[1] = d[0] ^ d[2] ^ d[3] ^ d[5] ^ d[6] ^ d[9] ^ d[10] ^ d[12] ^ d[13] ^ d[16]
             ^ d[17] ^ d[20] ^ d[21] ^ d[24] ^ d[25] ^ d[27] ^ d[28] ^ d[31] ^ d[32]
             ^ d[35] ^ d[36];
        p[2] = d[1] ^ d[2] ^ d[3] ^ d[7] ^ d[8] ^ d[9] ^ d[10] ^ d[14] ^ d[15] ^ d[16]
             ^ d[17] ^ d[22] ^ d[23] ^ d[24] ^ d[25] ^ d[29] ^ d[30] ^ d[31] ^ d[32]
             ^ d[37] ^ d[38];
        // contiguous groups
        p[3] = (^d[10:4]) ^ (^d[25:18]) ^ (^d[38:33]);
        p[4] = ^d[25:11];
        p[5] = ^d[38:26];
        // overall-ish parity term that makes every data column odd weight
        p[6] = d[0] ^ d[1] ^ d[2] ^ d[4] ^ d[5] ^ d[7] ^ d[10] ^ d[11] ^ d[12] ^ d[14]
             ^ d[17] ^ d[18] ^ d[21] ^ d[23] ^ d[24] ^ d[26] ^ d[27] ^ d[29] ^ d[32]
             ^ d[33] ^ d[36] ^ d[38];
        return p;
    endfunction

    // column of data bit i is the encoding of a one-hot word
    function automatic err_kind_e ecc_classify(
        input  syndrome_t              syn,
        output logic [`DATA_WIDTH-1:0] mask
    );
        logic [`DATA_WIDTH-1:0] one_hot;
        logic                   hit;
        err_kind_e              kind;
        mask = '0;
        hit  = 1'b0;
        for (int i = 0; i < `DATA_WIDTH; i++) begin
            one_hot = `DATA_WIDTH'(1) << i;
            if (ecc_encode(one_hot) == syn) begin
                mask[i] = 1'b1;
                hit     = 1'b1;
            end
        end
        if (syn == '0) begin
            kind = ERR_NONE;
        end else if (hit) begin
            kind = ERR_CORRECTED;
        end else if ((syn & (syn - 1'b1)) == '0) begin
            // lone check bit flipped
            kind = ERR_PARITY;
        end else begin
            kind = ERR_UNCORR;
        end
        return kind;
    endfunction

endpackage

//--- rtl/wb_pkg.sv
`include "fifo_settings.svh"

package wb_pkg;

    // read port register map
    typedef enum logic {
        RD_DATA   = 1'b0,
        RD_STATUS = 1'b1
    } rd_addr_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // status word, zero-extended on the bus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        logic [`ERR_CNT_WIDTH-1:0] corr_cnt;
        logic [`ERR_CNT_WIDTH-1:0] uncorr_cnt;
        logic                      last_uncorr;
        logic                      last_corr;
    } status_s;

endpackage

//--- rtl/ecc_wr_port.sv
`timescale 1ns/1ns
`include "fifo_settings.svh"

module ecc_wr_port (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         wr_cyc,
    input  logic                         wr_stb,
    input  logic                         wr_we,
    input  logic [`DATA_WIDTH-1:0]       wr_dat,
    output logic                         wr_ack,
    input  logic [ecc_pkg::CW_WIDTH-1:0] inj_mask,
    output logic                         push_valid,
    output ecc_pkg::codeword_u           push_cw,
    input  logic                         push_ready
);

    ecc_pkg::codeword_u enc_cw;
    logic               req;
    logic               ack_next;

    // stb stays up during the ack cycle, so mask it out there
    assign req        = wr_cyc & wr_stb & ~wr_ack;
    assign push_valid = req & wr_we;

    // reads on this port just complete
    assign ack_next = req & (~wr_we | push_ready);

    always_comb begin
        enc_cw.fields.data   = wr_dat;
        enc_cw.fields.parity = ecc_pkg::ecc_encode(wr_dat);
        // fault injection on the stored image
        push_cw.raw = enc_cw.raw ^ inj_mask;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ack <= 1'b0;
        end else begin
            wr_ack <= ack_next;
        end
    end

    // a stalled push stays offered unchanged
    a_push_held: assert property (@(posedge clk) disable iff (!rst_n)
        (push_valid && !push_ready) |=> (push_valid && $stable(push_cw)));

endmodule

//--- rtl/ecc_codeword_fifo.sv
`timescale 1ns/1ns
`include "fifo_settings.svh"

module ecc_codeword_fifo #(
    parameter int DEPTH = `FIFO_DEPTH
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               push_valid,
    input  ecc_pkg::codeword_u push_cw,
    output logic               push_ready,
    output logic               pop_valid,
    output ecc_pkg::codeword_u pop_cw,
    input  logic               pop_ready
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    ecc_pkg::codeword_u mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               push_fire;
    logic               pop_fire;
    logic               mem_empty;
    logic               load_out;
    logic               mem_wr;
    logic               mem_rd;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign push_fire = push_valid & push_ready;
    assign pop_fire  = pop_valid & pop_ready;

    // count covers the output register too
    assign push_ready = (count != CNT_W'(DEPTH)) | pop_fire;

    // array never holds more than DEPTH-1, so equal pointers mean empty
    assign mem_empty = (wr_ptr == rd_ptr);
    assign load_out  = ~pop_valid | pop_fire;
    assign mem_rd    = load_out & ~mem_empty;
    assign mem_wr    = push_fire & ~(load_out & mem_empty);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            pop_valid <= 1'b0;
        end else begin
            if (mem_wr) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (mem_rd) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            if (load_out) begin
                pop_valid <= ~mem_empty | push_fire;
            end
            count <= count + CNT_W'(push_fire) - CNT_W'(pop_fire);
        end
    end

    // storage and output word
    always_ff @(posedge clk) begin
        if (mem_wr) begin
            mem[wr_ptr] <= push_cw;
        end
        if (mem_rd) begin
            pop_cw <= mem[rd_ptr];
        end else if (load_out && push_fire) begin
            pop_cw <= push_cw;
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        count <= CNT_W'(DEPTH));

    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
        pop_fire |-> (count != '0));

endmodule

//--- rtl/ecc_rd_port.sv
`timescale 1ns/1ns
`include "fifo_settings.svh"

module ecc_rd_port (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   rd_cyc,
    input  logic                   rd_stb,
    input  wb_pkg::rd_addr_e       rd_adr,
    output logic [`DATA_WIDTH-1:0] rd_dat,
    output logic                   rd_ack,
    input  logic                   ecc_bypass,
    input  logic                   pop_valid,
    input  ecc_pkg::codeword_u     pop_cw,
    output logic                   pop_ready
);

    localparam int STATUS_PAD = `DATA_WIDTH - $bits(wb_pkg::status_s);
    localparam logic [`ERR_CNT_WIDTH-1:0] CNT_MAX = '1;

    logic                   req;
    logic                   status_req;
    logic                   pop_fire;
    ecc_pkg::syndrome_t     syndrome;
    ecc_pkg::err_kind_e     err_kind;
    logic [`DATA_WIDTH-1:0] corr_mask;
    logic [`DATA_WIDTH-1:0] dec_data;
    wb_pkg::status_s        status_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bus side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign req        = rd_cyc & rd_stb & ~rd_ack;
    assign pop_ready  = req & (rd_adr == wb_pkg::RD_DATA);
    assign status_req = req & (rd_adr == wb_pkg::RD_STATUS);
    assign pop_fire   = pop_valid & pop_ready;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        syndrome = ecc_pkg::ecc_encode(pop_cw.fields.data) ^ pop_cw.fields.parity;
        err_kind = ecc_pkg::ecc_classify(syndrome, corr_mask);
        // raw data when bypassed, double errors pass through untouched
        if (ecc_bypass) begin
            dec_data = pop_cw.fields.data;
        end else begin
            dec_data = pop_cw.fields.data ^ corr_mask;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ack   <= 1'b0;
            status_q <= '0;
        end else begin
            rd_ack <= pop_fire | status_req;
            if (pop_fire && !ecc_bypass) begin
                case (err_kind)
                    ecc_pkg::ERR_NONE: begin
                        status_q.last_corr   <= 1'b0;
                        status_q.last_uncorr <= 1'b0;
                    end
                    // check-bit hits count as corrected
                    ecc_pkg::ERR_CORRECTED, ecc_pkg::ERR_PARITY: begin
                        if (status_q.corr_cnt != CNT_MAX) begin
                            status_q.corr_cnt <= status_q.corr_cnt + 1'b1;
                        end
                        status_q.last_corr   <= 1'b1;
                        status_q.last_uncorr <= 1'b0;
                    end
                    default: begin
                        if (status_q.uncorr_cnt != CNT_MAX) begin
                            status_q.uncorr_cnt <= status_q.uncorr_cnt + 1'b1;
                        end
                        status_q.last_corr   <= 1'b0;
                        status_q.last_uncorr <= 1'b1;
                    end
                endcase
            end
        end
    end

    // read data register
    always_ff @(posedge clk) begin
        if (pop_fire) begin
            rd_dat <= dec_data;
        end else if (status_req) begin
            rd_dat <= {{STATUS_PAD{1'b0}}, status_q};
        end
    end

    // distinct data columns leave exactly one bit to flip
    a_fix_one_hot: assert property (@(posedge clk) disable iff (!rst_n)
        (pop_valid && err_kind == ecc_pkg::ERR_CORRECTED) |-> $onehot(corr_mask));

endmodule

//--- rtl/ecc_fifo_top.sv
`timescale 1ns/1ns
`include "fifo_settings.svh"

module ecc_fifo_top (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         wr_cyc,
    input  logic                         wr_stb,
    input  logic                         wr_we,
    input  logic [`DATA_WIDTH-1:0]       wr_dat,
    output logic                         wr_ack,
    input  logic                         rd_cyc,
    input  logic                         rd_stb,
    input  logic                         rd_adr,
    output logic [`DATA_WIDTH-1:0]       rd_dat,
    output logic                         rd_ack,
    input  logic [ecc_pkg::CW_WIDTH-1:0] inj_mask,
    input  logic                         ecc_bypass
);

    logic               push_valid;
    logic               push_ready;
    ecc_pkg::codeword_u push_cw;
    logic               pop_valid;
    logic               pop_ready;
    ecc_pkg::codeword_u pop_cw;

    ecc_wr_port u_wr_port (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_cyc     (wr_cyc),
        .wr_stb     (wr_stb),
        .wr_we      (wr_we),
        .wr_dat     (wr_dat),
        .wr_ack     (wr_ack),
        .inj_mask   (inj_mask),
        .push_valid (push_valid),
        .push_cw    (push_cw),
        .push_ready (push_ready)
    );

    ecc_codeword_fifo #(
        .DEPTH (`FIFO_DEPTH)
    ) u_fifo (
        .clk        (clk),
        .rst_n      (rst_n),
        .push_valid (push_valid),
        .push_cw    (push_cw),
        .push_ready (push_ready),
        .pop_valid  (pop_valid),
        .pop_cw     (pop_cw),
        .pop_ready  (pop_ready)
    );

    ecc_rd_port u_rd_port (
        .clk        (clk),
        .rst_n      (rst_n),
        .rd_cyc     (rd_cyc),
        .rd_stb     (rd_stb),
        .rd_adr     (wb_pkg::rd_addr_e'(rd_adr)),
        .rd_dat     (rd_dat),
        .rd_ack     (rd_ack),
        .ecc_bypass (ecc_bypass),
        .pop_valid  (pop_valid),
        .pop_cw     (pop_cw),
        .pop_ready  (pop_ready)
    );

endmodule

//--- tb/tb_ecc_fifo.sv
`timescale 1ns/1ns
`include "fifo_settings.svh"

module tb_ecc_fifo;

    localparam int DW = `DATA_WIDTH;
    localparam int CW = `DATA_WIDTH + `PARITY_WIDTH;
    localparam int N_CLEAN = 50;
    localparam int N_DOUBLE = 20;

    // one status read per test plus the data traffic
    localparam int TOTAL_ACCESSES = (2 * N_CLEAN + 1) + (2 * CW + 1) + (2 * N_DOUBLE + 1)
                                  + 4 + 2 * (`FIFO_DEPTH + 2) + 3;
    localparam int TIMEOUT_CYCLES = 20 * TOTAL_ACCESSES;

    localparam int KIND_NONE   = 0;
    localparam int KIND_CORR   = 1;
    localparam int KIND_UNCORR = 2;
    localparam int KIND_RAW    = 3;

    logic          clk;
    logic          rst_n;
    logic          wr_cyc;
    logic          wr_stb;
    logic          wr_we;
    logic [DW-1:0] wr_dat;
    logic          wr_ack;
    logic          rd_cyc;
    logic          rd_stb;
    logic          rd_adr;
    logic [DW-1:0] rd_dat;
    logic          rd_ack;
    logic [CW-1:0] inj_mask;
    logic          ecc_bypass;

    logic [DW-1:0] sent_data_q [$];
    logic [CW-1:0] sent_mask_q [$];
    string         exp_name_q [$];
    logic [DW-1:0] exp_value_q [$];

    logic [`ERR_CNT_WIDTH-1:0] exp_corr;
    logic [`ERR_CNT_WIDTH-1:0] exp_uncorr;
    logic                      exp_last_corr;
    logic                      exp_last_uncorr;

    string test_name;
    int    read_index;
    int    cycle_count;
    int    wr_ack_count;
    int    rd_ack_count;

    ecc_fifo_top dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_cyc     (wr_cyc),
        .wr_stb     (wr_stb),
        .wr_we      (wr_we),
        .wr_dat     (wr_dat),
        .wr_ack     (wr_ack),
        .rd_cyc     (rd_cyc),
        .rd_stb     (rd_stb),
        .rd_adr     (rd_adr),
        .rd_dat     (rd_dat),
        .rd_ack     (rd_ack),
        .inj_mask   (inj_mask),
        .ecc_bypass (ecc_bypass)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // odd-weight data columns and unit check columns decide the outcome
    function automatic logic [DW-1:0] expect_read(
        input  logic [DW-1:0] data,
        input  logic [CW-1:0] mask,
        input  logic          bypass,
        output int            kind
    );
        logic [DW-1:0] flipped;
        logic [DW-1:0] result;
        int            weight;
        flipped = data ^ mask[DW-1:0];
        weight  = $countones(mask);
        if (bypass) begin
            kind   = KIND_RAW;
            result = flipped;
        end else if (weight == 0) begin
            kind   = KIND_NONE;
            result = data;
        end else if (weight == 1) begin
            kind   = KIND_CORR;
            result = data;
        end else begin
            kind   = KIND_UNCORR;
            result = flipped;
        end
        return result;
    endfunction

    task automatic note_outcome(input int kind);
        if (kind == KIND_NONE) begin
            exp_last_corr   = 1'b0;
            exp_last_uncorr = 1'b0;
        end else if (kind == KIND_CORR) begin
            if (exp_corr != '1) exp_corr = exp_corr + 1'b1;
            exp_last_corr   = 1'b1;
            exp_last_uncorr = 1'b0;
        end else if (kind == KIND_UNCORR) begin
            if (exp_uncorr != '1) exp_uncorr = exp_uncorr + 1'b1;
            exp_last_corr   = 1'b0;
            exp_last_uncorr = 1'b1;
        end
    endtask

    function automatic logic [DW-1:0] status_word();
        return DW'({exp_corr, exp_uncorr, exp_last_uncorr, exp_last_corr});
    endfunction

    function automatic logic [DW-1:0] rand_word();
        logic [63:0] r;
        r = {$urandom(), $urandom()};
        return r[DW-1:0];
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checking
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [DW-1:0] expected,
                               input logic [DW-1:0] actual);
        if (actual !== expected) begin
            stop_on_error($sformatf("CHECK FAILED %s expected=%h actual=%h",
                                    name, expected, actual));
        end
    endtask

    always @(negedge clk) begin
        if (rst_n && wr_ack) wr_ack_count++;
        if (rst_n && rd_ack) begin
            rd_ack_count++;
            if (exp_name_q.size() == 0) begin
                stop_on_error("read acknowledged with no expected value queued");
            end else begin
                check_value(exp_name_q.pop_front(), exp_value_q.pop_front(), rd_dat);
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            stop_on_error($sformatf("run did not finish within %0d cycles", TIMEOUT_CYCLES));
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bus tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic queue_data_expect();
        logic [DW-1:0] data;
        logic [CW-1:0] mask;
        logic [DW-1:0] exp;
        int            kind;
        data = sent_data_q.pop_front();
        mask = sent_mask_q.pop_front();
        exp  = expect_read(data, mask, ecc_bypass, kind);
        note_outcome(kind);
        exp_name_q.push_back($sformatf("%s data read %0d", test_name, read_index));
        exp_value_q.push_back(exp);
        read_index++;
    endtask

    task automatic wb_write(input logic [DW-1:0] data, input logic [CW-1:0] mask);
        @(posedge clk);
        #1;
        wr_cyc   = 1'b1;
        wr_stb   = 1'b1;
        wr_we    = 1'b1;
        wr_dat   = data;
        inj_mask = mask;
        sent_data_q.push_back(data);
        sent_mask_q.push_back(mask);
        @(negedge clk);
        while (!wr_ack) @(negedge clk);
        @(posedge clk);
        #1;
        wr_cyc   = 1'b0;
        wr_stb   = 1'b0;
        wr_we    = 1'b0;
        inj_mask = '0;
    endtask

    task automatic wb_read(input logic adr);
        @(posedge clk);
        #1;
        rd_cyc = 1'b1;
        rd_stb = 1'b1;
        rd_adr = adr;
        if (adr) begin
            exp_name_q.push_back($sformatf("%s status read", test_name));
            exp_value_q.push_back(status_word());
        end else begin
            // the matching write may still be on its way
            while (sent_data_q.size() == 0) @(negedge clk);
            queue_data_expect();
        end
        @(negedge clk);
        while (!rd_ack) @(negedge clk);
        @(posedge clk);
        #1;
        rd_cyc = 1'b0;
        rd_stb = 1'b0;
        rd_adr = 1'b0;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        int            pos_a;
        int            pos_b;
        int            acks_before;
        logic [CW-1:0] mask;
        rst_n = 1'b0;
        wr_cyc = 1'b0;
        wr_stb = 1'b0;
        wr_we = 1'b0;
        wr_dat = '0;
        rd_cyc = 1'b0;
        rd_stb = 1'b0;
        rd_adr = 1'b0;
        inj_mask = '0;
        ecc_bypass = 1'b0;
        exp_corr = '0;
        exp_uncorr = '0;
        exp_last_corr = 1'b0;
        exp_last_uncorr = 1'b0;
        read_index = 0;
        cycle_count = 0;
        wr_ack_count = 0;
        rd_ack_count = 0;
        void'($urandom(32'ha823_21b7));
        repeat (4) @(posedge clk);
        #1 rst_n = 1'b1;

        // more words than slots, so the reader drains alongside
        test_name = "t1_clean";
        fork
            for (int i = 0; i < N_CLEAN; i++) wb_write(rand_word(), '0);
            for (int i = 0; i < N_CLEAN; i++) wb_read(1'b0);
        join
        wb_read(1'b1);

        // every data and every check position
        test_name = "t2_single_bit";
        for (int p = 0; p < CW; p++) begin
            wb_write(rand_word(), CW'(1) << p);
            wb_read(1'b0);
        end
        wb_read(1'b1);

        test_name = "t3_double_bit";
        for (int i = 0; i < N_DOUBLE; i++) begin
            pos_a = $urandom_range(CW - 1, 0);
            pos_b = pos_a;
            while (pos_b == pos_a) pos_b = $urandom_range(CW - 1, 0);
            mask = (CW'(1) << pos_a) | (CW'(1) << pos_b);
            wb_write(rand_word(), mask);
            wb_read(1'b0);
        end
        wb_read(1'b1);

        test_name = "t4_bypass";
        wb_read(1'b1);
        @(posedge clk);
        #1 ecc_bypass = 1'b1;
        pos_a = $urandom_range(DW - 1, 0);
        wb_write(rand_word(), CW'(1) << pos_a);
        wb_read(1'b0);
        wb_read(1'b1);
        @(posedge clk);
        #1 ecc_bypass = 1'b0;

        test_name = "t5_backpressure";
        acks_before = wr_ack_count;
        for (int i = 0; i < `FIFO_DEPTH; i++) wb_write(rand_word(), '0);
        fork
            begin
                wb_write(rand_word(), '0);
                wb_write(rand_word(), '0);
            end
            begin
                repeat (8) @(negedge clk);
                check_value("t5_backpressure acks while full",
                            DW'(acks_before + `FIFO_DEPTH), DW'(wr_ack_count));
                for (int i = 0; i < `FIFO_DEPTH + 2; i++) wb_read(1'b0);
            end
        join
        check_value("t5_backpressure total acks",
                    DW'(acks_before + `FIFO_DEPTH + 2), DW'(wr_ack_count));

        test_name = "t6_empty_stall";
        wb_read(1'b1);
        acks_before = rd_ack_count;
        fork
            wb_read(1'b0);
            begin
                repeat (6) @(negedge clk);
                check_value("t6_empty_stall acks while empty",
                            DW'(acks_before), DW'(rd_ack_count));
                wb_write(rand_word(), '0);
            end
        join
        check_value("t6_empty_stall total acks", DW'(acks_before + 1), DW'(rd_ack_count));

        if (exp_name_q.size() != 0 || sent_data_q.size() != 0) begin
            stop_on_error("words left unread or expected reads never acknowledged");
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

//--- verilog.f
+incdir+rtl
rtl/ecc_pkg.sv
rtl/wb_pkg.sv
rtl/ecc_wr_port.sv
rtl/ecc_codeword_fifo.sv
rtl/ecc_rd_port.sv
rtl/ecc_fifo_top.sv
tb/tb_ecc_fifo.sv

//--- Makefile
# Verilator flow for the ECC word FIFO
VERILATOR ?= verilator
TOP       ?= tb_ecc_fifo
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
JOBS      ?= 4

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := rtl/fifo_settings.svh

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) -f $(FILELIST) \
		--top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
